// ==== cnn_pkg.sv ====
`default_nettype none

package cnn_pkg;

    // Image and kernel geometry
    localparam int IMG_W    = 12;
    localparam int KERNEL_W = 5;

    // Valid convolution shrinks the image by the kernel border
    localparam int CONV_W   = IMG_W - KERNEL_W + 1;

    // 2x2 pooling halves each side
    localparam int POOL_W   = CONV_W / 2;

    // Unsigned image sample
    typedef logic [7:0] pixel_t;

    // Kernel weight and bias share one signed byte format
    typedef logic signed [7:0] weight_t;

    // Sum of 25 products plus bias
    typedef logic signed [19:0] acc_t;

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // One byte per scratch location
    typedef logic [7:0] addr_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        addr_t      addr;
        logic [7:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic       gnt;
        logic       rvalid;
        logic [7:0] rdata;
    } mem_rsp_t;

    localparam int MEM_DEPTH = 256;

    // Scratch layout
    localparam int IMG_BASE  = 0;
    localparam int KERN_BASE = 144;
    localparam int BIAS_BASE = 169;
    localparam int CONV_BASE = 176;
    localparam int POOL_BASE = 240;

endpackage

`default_nettype wire

// ==== scratch_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module scratch_mem
    import cnn_pkg::*;
    import mem_pkg::*;
#(
    parameter int MEM_DEPTH = mem_pkg::MEM_DEPTH
) (
    input  logic     clk,
    input  mem_req_t req,
    output pixel_t   rdata
);

    pixel_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (req.valid && req.we) begin
            mem[req.addr] <= req.wdata;
        end
        // Read data shows up one cycle after the request
        if (req.valid && !req.we) begin
            rdata <= mem[req.addr];
        end
    end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import cnn_pkg::*;
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t host_req,
    input  mem_req_t conv_req,
    input  mem_req_t pool_req,
    output mem_rsp_t host_rsp,
    output mem_rsp_t conv_rsp,
    output mem_rsp_t pool_rsp,
    output mem_req_t mem_req,
    input  pixel_t   mem_rdata
);

    logic       gnt_conv;
    logic       gnt_pool;
    logic       gnt_host;
    // Read owners of last cycle in conv, pool, host order
    logic [2:0] rd_owner;

    // Conv has the highest priority
    assign gnt_conv = conv_req.valid;
    assign gnt_pool = pool_req.valid && !conv_req.valid;
    assign gnt_host = host_req.valid && !conv_req.valid && !pool_req.valid;

    always_comb begin
        if (gnt_conv) begin
            mem_req = conv_req;
        end else if (gnt_pool) begin
            mem_req = pool_req;
        end else if (gnt_host) begin
            mem_req = host_req;
        end else begin
            mem_req = '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_owner <= '0;
        end else begin
            rd_owner <= {gnt_conv && !conv_req.we,
                         gnt_pool && !pool_req.we,
                         gnt_host && !host_req.we};
        end
    end

    assign conv_rsp = '{gnt: gnt_conv, rvalid: rd_owner[2], rdata: mem_rdata};
    assign pool_rsp = '{gnt: gnt_pool, rvalid: rd_owner[1], rdata: mem_rdata};
    assign host_rsp = '{gnt: gnt_host, rvalid: rd_owner[0], rdata: mem_rdata};

    // A denied request waits unchanged for its grant
    a_host_hold: assert property (@(posedge clk) disable iff (reset)
        host_req.valid && !gnt_host |=> host_req.valid && $stable(host_req));

    a_pool_hold: assert property (@(posedge clk) disable iff (reset)
        pool_req.valid && !gnt_pool |=> pool_req.valid && $stable(pool_req));

endmodule

`default_nettype wire

// ==== apb_host_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module apb_host_port
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp,
    output logic        conv_start,
    input  logic        conv_done,
    output logic        pool_start,
    input  logic        pool_done
);

    logic access;
    logic ctrl_hit;
    logic status_hit;
    logic win_hit;
    logic rd_wait;
    logic start_req;
    logic busy;
    logic done;

    assign access     = psel && penable;
    assign ctrl_hit   = paddr == 12'h000;
    assign status_hit = paddr == 12'h004;
    // Window covers 0x400 to 0x7ff, one location per word
    assign win_hit    = paddr[11:10] == 2'b01;
    assign pslverr    = access && !(ctrl_hit || status_hit || win_hit);
    assign start_req  = access && ctrl_hit && pwrite && pwdata[0] && !busy;

    // Hold the request until granted, then wait for the read data
    always_comb begin
        mem_req.valid = access && win_hit && !rd_wait;
        mem_req.we    = pwrite;
        mem_req.addr  = paddr[9:2];
        mem_req.wdata = pwdata[7:0];
    end

    always_comb begin
        pready = 1'b0;
        prdata = '0;
        if (access) begin
            if (win_hit) begin
                pready = pwrite ? mem_rsp.gnt : mem_rsp.rvalid;
                prdata = {24'b0, mem_rsp.rdata};
            end else begin
                pready = 1'b1;
                if (status_hit) begin
                    prdata = {30'b0, done, busy};
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_wait    <= 1'b0;
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            rd_wait    <= mem_rsp.gnt && !mem_req.we;
            conv_start <= start_req;
            // Pooling follows the convolution directly
            pool_start <= conv_done;
            if (start_req) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (pool_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    a_apb_hold: assert property (@(posedge clk) disable iff (reset)
        psel && penable && !pready |=> $stable(paddr) && $stable(pwrite));

endmodule

`default_nettype wire

// ==== conv_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_engine
    import cnn_pkg::*;
    import mem_pkg::*;
#(
    parameter int IMG_W     = cnn_pkg::IMG_W,
    parameter int KERNEL_W  = cnn_pkg::KERNEL_W,
    parameter int CONV_W    = cnn_pkg::CONV_W,
    parameter int IMG_BASE  = mem_pkg::IMG_BASE,
    parameter int KERN_BASE = mem_pkg::KERN_BASE,
    parameter int BIAS_BASE = mem_pkg::BIAS_BASE,
    parameter int CONV_BASE = mem_pkg::CONV_BASE
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    output logic     done,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    localparam int TAPS = KERNEL_W * KERNEL_W;
    localparam int CW   = $clog2(TAPS + 2);
    localparam int KW   = $clog2(KERNEL_W);
    localparam int OW   = $clog2(CONV_W);

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_READ, S_WRITE} state_t;

    state_t             state;
    logic [CW-1:0]      iss_cnt;
    logic [CW-1:0]      rcv_cnt;
    logic [KW-1:0]      kx;
    logic [OW-1:0]      ocol;
    addr_t              tap_addr;
    addr_t              pos_addr;
    addr_t              next_pos;
    addr_t              wr_addr;
    weight_t            weights [TAPS];
    weight_t            bias;
    acc_t               acc;
    logic signed [16:0] prod;
    pixel_t             result;
    logic               rd_grant;
    logic               last_rsp;
    logic               last_pos;

    assign rd_grant = mem_rsp.gnt && !mem_req.we;
    assign last_rsp = mem_rsp.rvalid &&
                      rcv_cnt == (state == S_LOAD ? CW'(TAPS) : CW'(TAPS - 1));
    assign last_pos = wr_addr == addr_t'(CONV_BASE + CONV_W * CONV_W - 1);
    assign prod     = $signed({1'b0, mem_rsp.rdata}) * weights[rcv_cnt];

    // Top-left pixel of the next output window
    assign next_pos = (ocol == OW'(CONV_W - 1)) ? pos_addr + addr_t'(IMG_W - CONV_W + 1)
                                                 : pos_addr + addr_t'(1);

    // Clamp to the pixel range
    always_comb begin
        if (acc < 0) begin
            result = '0;
        end else if (acc > 255) begin
            result = 8'hff;
        end else begin
            result = acc[7:0];
        end
    end

    always_comb begin
        mem_req = '0;
        case (state)
            S_LOAD: begin
                // 25 weights, then the bias
                mem_req.valid = iss_cnt <= CW'(TAPS);
                mem_req.addr  = (iss_cnt < CW'(TAPS)) ? addr_t'(KERN_BASE + iss_cnt)
                                                      : addr_t'(BIAS_BASE);
            end
            S_READ: begin
                mem_req.valid = iss_cnt < CW'(TAPS);
                mem_req.addr  = tap_addr;
            end
            S_WRITE: begin
                mem_req.valid = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = wr_addr;
                mem_req.wdata = result;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            iss_cnt  <= '0;
            rcv_cnt  <= '0;
            kx       <= '0;
            ocol     <= '0;
            tap_addr <= '0;
            pos_addr <= '0;
            wr_addr  <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (rd_grant) begin
                iss_cnt <= iss_cnt + CW'(1);
            end
            if (mem_rsp.rvalid) begin
                rcv_cnt <= rcv_cnt + CW'(1);
            end
            // Walk the kernel window row by row
            if (rd_grant && state == S_READ) begin
                if (kx == KW'(KERNEL_W - 1)) begin
                    kx       <= '0;
                    tap_addr <= tap_addr + addr_t'(IMG_W - KERNEL_W + 1);
                end else begin
                    kx       <= kx + KW'(1);
                    tap_addr <= tap_addr + addr_t'(1);
                end
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_LOAD;
                        ocol     <= '0;
                        pos_addr <= addr_t'(IMG_BASE);
                        tap_addr <= addr_t'(IMG_BASE);
                        wr_addr  <= addr_t'(CONV_BASE);
                    end
                end
                S_LOAD: begin
                    if (last_rsp) begin
                        state   <= S_READ;
                        iss_cnt <= '0;
                        rcv_cnt <= '0;
                    end
                end
                S_READ: begin
                    if (last_rsp) begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (mem_rsp.gnt) begin
                        iss_cnt  <= '0;
                        rcv_cnt  <= '0;
                        wr_addr  <= wr_addr + addr_t'(1);
                        pos_addr <= next_pos;
                        tap_addr <= next_pos;
                        ocol     <= (ocol == OW'(CONV_W - 1)) ? '0 : ocol + OW'(1);
                        if (last_pos) begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                        end else begin
                            state <= S_READ;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp.rvalid) begin
            if (state == S_LOAD) begin
                if (rcv_cnt < CW'(TAPS)) begin
                    weights[rcv_cnt] <= weight_t'(mem_rsp.rdata);
                end else begin
                    bias <= weight_t'(mem_rsp.rdata);
                end
            end else begin
                // First tap of a window starts from the bias
                acc <= (rcv_cnt == '0 ? acc_t'(bias) : acc) + acc_t'(prod);
            end
        end
    end

    a_no_stray_rvalid: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.rvalid |-> iss_cnt != rcv_cnt);

endmodule

`default_nettype wire

// ==== pool_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module pool_engine
    import cnn_pkg::*;
    import mem_pkg::*;
#(
    parameter int CONV_W    = cnn_pkg::CONV_W,
    parameter int POOL_W    = cnn_pkg::POOL_W,
    parameter int CONV_BASE = mem_pkg::CONV_BASE,
    parameter int POOL_BASE = mem_pkg::POOL_BASE
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    output logic     done,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    localparam int PW = $clog2(POOL_W);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE} state_t;

    state_t        state;
    logic [2:0]    iss_cnt;
    logic [2:0]    rcv_cnt;
    logic [PW-1:0] pcol;
    addr_t         win_addr;
    addr_t         wr_addr;
    pixel_t        max_val;
    logic          rd_grant;
    logic          last_rsp;
    logic          last_win;

    assign rd_grant = mem_rsp.gnt && !mem_req.we;
    assign last_rsp = mem_rsp.rvalid && rcv_cnt == 3'd3;
    assign last_win = wr_addr == addr_t'(POOL_BASE + POOL_W * POOL_W - 1);

    always_comb begin
        mem_req       = '0;
        mem_req.addr  = wr_addr;
        mem_req.wdata = max_val;
        if (state == S_READ && iss_cnt < 3'd4) begin
            // Bit 1 picks the lower row, bit 0 the right column
            mem_req.valid = 1'b1;
            mem_req.addr  = win_addr + (iss_cnt[1] ? addr_t'(CONV_W) : '0) +
                            addr_t'(iss_cnt[0]);
        end else if (state == S_WRITE) begin
            mem_req.valid = 1'b1;
            mem_req.we    = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            iss_cnt  <= '0;
            rcv_cnt  <= '0;
            pcol     <= '0;
            win_addr <= '0;
            wr_addr  <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (rd_grant) begin
                iss_cnt <= iss_cnt + 3'd1;
            end
            if (mem_rsp.rvalid) begin
                rcv_cnt <= rcv_cnt + 3'd1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_READ;
                        pcol     <= '0;
                        win_addr <= addr_t'(CONV_BASE);
                        wr_addr  <= addr_t'(POOL_BASE);
                    end
                end
                S_READ: begin
                    if (last_rsp) begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (mem_rsp.gnt) begin
                        iss_cnt <= '0;
                        rcv_cnt <= '0;
                        wr_addr <= wr_addr + addr_t'(1);
                        // Skip the odd row at the end of each window row
                        if (pcol == PW'(POOL_W - 1)) begin
                            pcol     <= '0;
                            win_addr <= win_addr + addr_t'(2 * CONV_W - 2 * POOL_W + 2);
                        end else begin
                            pcol     <= pcol + PW'(1);
                            win_addr <= win_addr + addr_t'(2);
                        end
                        if (last_win) begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                        end else begin
                            state <= S_READ;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Running maximum, restarted by the first value of each window
    always_ff @(posedge clk) begin
        if (mem_rsp.rvalid && (rcv_cnt == 3'd0 || mem_rsp.rdata > max_val)) begin
            max_val <= mem_rsp.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== cnn_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cnn_top
    import cnn_pkg::*;
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    mem_req_t host_req;
    mem_req_t conv_req;
    mem_req_t pool_req;
    mem_req_t mem_req;
    mem_rsp_t host_rsp;
    mem_rsp_t conv_rsp;
    mem_rsp_t pool_rsp;
    pixel_t   mem_rdata;
    logic     conv_start;
    logic     conv_done;
    logic     pool_start;
    logic     pool_done;

    apb_host_port host0 (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .mem_req    (host_req),
        .mem_rsp    (host_rsp),
        .conv_start (conv_start),
        .conv_done  (conv_done),
        .pool_start (pool_start),
        .pool_done  (pool_done)
    );

    conv_engine #(
        .IMG_W     (IMG_W),
        .KERNEL_W  (KERNEL_W),
        .CONV_W    (CONV_W),
        .IMG_BASE  (IMG_BASE),
        .KERN_BASE (KERN_BASE),
        .BIAS_BASE (BIAS_BASE),
        .CONV_BASE (CONV_BASE)
    ) conv0 (
        .clk     (clk),
        .reset   (reset),
        .start   (conv_start),
        .done    (conv_done),
        .mem_req (conv_req),
        .mem_rsp (conv_rsp)
    );

    pool_engine #(
        .CONV_W    (CONV_W),
        .POOL_W    (POOL_W),
        .CONV_BASE (CONV_BASE),
        .POOL_BASE (POOL_BASE)
    ) pool0 (
        .clk     (clk),
        .reset   (reset),
        .start   (pool_start),
        .done    (pool_done),
        .mem_req (pool_req),
        .mem_rsp (pool_rsp)
    );

    mem_arbiter arb0 (
        .clk       (clk),
        .reset     (reset),
        .host_req  (host_req),
        .conv_req  (conv_req),
        .pool_req  (pool_req),
        .host_rsp  (host_rsp),
        .conv_rsp  (conv_rsp),
        .pool_rsp  (pool_rsp),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    scratch_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) mem0 (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_cnn.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cnn
    import cnn_pkg::*;
    import mem_pkg::*;
();

    localparam int          CLK_PERIOD   = 100;
    localparam int          SAMPLE_DELAY = 10;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] SEED         = 32'h6f35;
    localparam logic [11:0] CTRL_ADDR    = 12'h000;
    localparam logic [11:0] STATUS_ADDR  = 12'h004;
    localparam logic [11:0] WIN_ADDR     = 12'h400;

    // Watchdog budget from the test traffic
    localparam int NUM_RUNS          = 4;
    localparam int LOAD_ACCESSES     = IMG_W * IMG_W + KERNEL_W * KERNEL_W + 1;
    localparam int CHECK_ACCESSES    = CONV_W * CONV_W + POOL_W * POOL_W;
    localparam int OTHER_ACCESSES    = 40;
    localparam int NUM_ACCESSES      = 2 * MEM_DEPTH + OTHER_ACCESSES +
                                       NUM_RUNS * (LOAD_ACCESSES + CHECK_ACCESSES + 1);
    localparam int CYCLES_PER_ACCESS = 40;
    localparam int CYCLES_PER_RUN    = 4000;
    localparam int WATCHDOG_CYCLES   = RESET_CYCLES + NUM_ACCESSES * CYCLES_PER_ACCESS +
                                       NUM_RUNS * CYCLES_PER_RUN;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Reference copy of the layer inputs
    int          img [IMG_W * IMG_W];
    int          kern [KERNEL_W * KERNEL_W];
    int          bias;
    logic [7:0]  shadow [MEM_DEPTH];

    string       test_name;
    int          error_count;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    cnn_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [11:0] window_addr(input int loc);
        return WIN_ADDR + 12'(loc * 4);
    endfunction

    function automatic int clamp_pixel(input int value);
        if (value < 0) begin
            return 0;
        end
        return (value > 255) ? 255 : value;
    endfunction

    function automatic int conv_ref(input int r, input int c);
        int sum;
        sum = bias;
        for (int i = 0; i < KERNEL_W; i++) begin
            for (int j = 0; j < KERNEL_W; j++) begin
                sum += img[(r + i) * IMG_W + c + j] * kern[i * KERNEL_W + j];
            end
        end
        return clamp_pixel(sum);
    endfunction

    function automatic int pool_ref(input int pr, input int pc);
        int max_val;
        int value;
        max_val = 0;
        for (int dy = 0; dy < 2; dy++) begin
            for (int dx = 0; dx < 2; dx++) begin
                value = conv_ref(2 * pr + dy, 2 * pc + dx);
                if (value > max_val) begin
                    max_val = value;
                end
            end
        end
        return max_val;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("ERROR %s: %s", test_name, msg);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("[ok]   %s", test_name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s, %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    // One APB transfer with setup and access phases
    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(SAMPLE_DELAY);
        while (pready !== 1'b1) begin
            @(negedge clk);
            #(SAMPLE_DELAY);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check_true(!err, $sformatf("error response on write to 0x%03h", addr));
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_true(!err, $sformatf("error response on read from 0x%03h", addr));
    endtask

    task automatic load_layer();
        for (int i = 0; i < IMG_W * IMG_W; i++) begin
            apb_write(window_addr(IMG_BASE + i), 32'(img[i]));
        end
        for (int i = 0; i < KERNEL_W * KERNEL_W; i++) begin
            apb_write(window_addr(KERN_BASE + i), 32'(kern[i]) & 32'hff);
        end
        apb_write(window_addr(BIAS_BASE), 32'(bias) & 32'hff);
    endtask

    task automatic wait_for_done();
        logic [31:0] status;
        do begin
            apb_read(STATUS_ADDR, status);
        end while (status[1] !== 1'b1);
        check_value("busy after done", 32'd0, {31'b0, status[0]});
    endtask

    task automatic start_and_wait();
        apb_write(CTRL_ADDR, 32'd1);
        wait_for_done();
    endtask

    // Compare both result regions with the model or with one fixed value
    task automatic check_results(input logic use_model, input int fixed_val);
        logic [31:0] data;
        int          exp;
        for (int r = 0; r < CONV_W; r++) begin
            for (int c = 0; c < CONV_W; c++) begin
                apb_read(window_addr(CONV_BASE + r * CONV_W + c), data);
                exp = use_model ? conv_ref(r, c) : fixed_val;
                check_value($sformatf("conv[%0d][%0d]", r, c), 32'(exp), data);
            end
        end
        for (int r = 0; r < POOL_W; r++) begin
            for (int c = 0; c < POOL_W; c++) begin
                apb_read(window_addr(POOL_BASE + r * POOL_W + c), data);
                exp = use_model ? pool_ref(r, c) : fixed_val;
                check_value($sformatf("pool[%0d][%0d]", r, c), 32'(exp), data);
            end
        end
    endtask

    // Weights kept within +-64 so the 20 bit accumulator cannot wrap
    task automatic random_layer();
        for (int i = 0; i < IMG_W * IMG_W; i++) begin
            img[i] = int'($urandom_range(255));
        end
        for (int i = 0; i < KERNEL_W * KERNEL_W; i++) begin
            kern[i] = int'($urandom_range(127)) - 64;
        end
        bias = int'($urandom_range(255)) - 128;
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        start_test("reset_state");
        apb_read(STATUS_ADDR, data);
        check_value("STATUS", 32'd0, data);
        apb_read(CTRL_ADDR, data);
        check_value("CTRL", 32'd0, data);
        apb_write(CTRL_ADDR, 32'd0);
        apb_read(STATUS_ADDR, data);
        check_value("STATUS after CTRL write of 0", 32'd0, data);
        end_test();
    endtask

    task automatic test_memory_window();
        logic [31:0] data;
        start_test("memory_window");
        for (int i = 0; i < MEM_DEPTH; i++) begin
            shadow[i] = 8'($urandom());
            apb_write(window_addr(i), {24'b0, shadow[i]});
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            apb_read(window_addr(i), data);
            check_value($sformatf("mem[%0d]", i), {24'b0, shadow[i]}, data);
        end
        end_test();
    endtask

    task automatic test_unmapped();
        logic [31:0] data;
        logic        err;
        start_test("unmapped");
        // Both alias location 0 and 255 in their low address bits
        apb_access(1'b1, 12'h800, {24'b0, ~shadow[0]}, data, err);
        check_true(err, "no error response on write to 0x800");
        apb_access(1'b1, 12'hffc, {24'b0, ~shadow[MEM_DEPTH - 1]}, data, err);
        check_true(err, "no error response on write to 0xffc");
        apb_access(0, 12'h00c, 32'd0, data, err);
        check_true(err, "no error response on read from 0x00c");
        apb_read(window_addr(0), data);
        check_value("mem[0]", {24'b0, shadow[0]}, data);
        apb_read(window_addr(MEM_DEPTH - 1), data);
        check_value("mem[255]", {24'b0, shadow[MEM_DEPTH - 1]}, data);
        apb_read(STATUS_ADDR, data);
        check_value("STATUS", 32'd0, data);
        end_test();
    endtask

    task automatic test_full_run();
        start_test("full_run");
        random_layer();
        load_layer();
        start_and_wait();
        check_results(1'b1, 0);
        end_test();
    endtask

    task automatic test_clamping();
        start_test("clamping");
        for (int i = 0; i < IMG_W * IMG_W; i++) begin
            img[i] = 255;
        end
        for (int i = 0; i < KERNEL_W * KERNEL_W; i++) begin
            kern[i] = int'($urandom_range(20, 1));
        end
        bias = int'($urandom_range(127));
        load_layer();
        start_and_wait();
        check_results(1'b0, 255);
        // Negative weights and bias drive every sum below zero
        for (int i = 0; i < IMG_W * IMG_W; i++) begin
            img[i] = int'($urandom_range(255));
        end
        for (int i = 0; i < KERNEL_W * KERNEL_W; i++) begin
            kern[i] = -int'($urandom_range(20, 1));
        end
        bias = -int'($urandom_range(128, 1));
        load_layer();
        start_and_wait();
        check_results(1'b0, 0);
        end_test();
    endtask

    task automatic test_busy_access();
        logic [31:0] data;
        start_test("busy_access");
        random_layer();
        load_layer();
        apb_write(CTRL_ADDR, 32'd1);
        apb_read(STATUS_ADDR, data);
        check_value("STATUS while busy", 32'd1, data);
        apb_write(CTRL_ADDR, 32'd1);
        apb_read(STATUS_ADDR, data);
        check_value("STATUS after second start", 32'd1, data);
        // Window read has to wait for a free memory cycle
        apb_read(window_addr(IMG_BASE + 77), data);
        check_value("img[77] while busy", 32'(img[77]), data);
        wait_for_done();
        check_results(1'b1, 0);
        end_test();
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_memory_window();
        test_unmapped();
        test_full_run();
        test_clamping();
        test_busy_access();

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
cnn_pkg.sv
mem_pkg.sv
scratch_mem.sv
mem_arbiter.sv
apb_host_port.sv
conv_engine.sv
pool_engine.sv
cnn_top.sv
tb_cnn.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cnn
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
FAIL_MSG  ?= Some tests failed

FILE_LIST := list.f
SOURCES   := $(shell cat $(FILE_LIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
